// File: cbPkg.sv
// Types, register indices, ALU operations and flag layout of the CB instruction group.
package cbPkg;

    typedef logic [7:0]  byteT;
    typedef logic [15:0] addrT;
    typedef logic [2:0]  regSelT;
    typedef logic [7:0]  flagsT;

    // Register order of the r field.
    localparam regSelT REG_B   = 3'd0;
    localparam regSelT REG_C   = 3'd1;
    localparam regSelT REG_D   = 3'd2;
    localparam regSelT REG_E   = 3'd3;
    localparam regSelT REG_H   = 3'd4;
    localparam regSelT REG_L   = 3'd5;
    localparam regSelT REG_MEM = 3'd6;
    localparam regSelT REG_A   = 3'd7;

    typedef enum logic [3:0] {
        NOP, RLC, RRC, RL, RR, SLA, SRA, SRL, BIT, RES, SET
    } aluOpT;

    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_H  = 4;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

    // Flags written by the shift group and by BIT.
    localparam flagsT FLAGS_SHIFT = 8'b1101_0111;
    localparam flagsT FLAGS_BIT   = 8'b1101_0110;

endpackage

// File: ctrlPkg.sv
// Microstep numbering and state encoding for the CB step sequencer.
package ctrlPkg;

    typedef logic [1:0] stepT;

    // A register operand finishes in step 1 and a memory operand in step 2.
    localparam stepT PLAIN_LAST = 2'd1;
    localparam stepT IDX_LAST   = 2'd2;

    typedef enum logic [1:0] {
        IDLE,
        PLAIN,
        INDEXED
    } seqStateT;

endpackage

// File: cbStepSequencer.sv
// Step counter that runs one plain or indexed CB instruction and pulses done.
module cbStepSequencer (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  logic          startIdx,
    input  logic          isRegOp,
    output ctrlPkg::stepT step,
    output logic          notEnablePlain,
    output logic          notEnableIdx,
    output logic          done
);

    ctrlPkg::seqStateT state;
    ctrlPkg::stepT     xpt;
    ctrlPkg::stepT     lastStep;

    assign lastStep = (state == ctrlPkg::PLAIN && isRegOp) ? ctrlPkg::PLAIN_LAST
                                                          : ctrlPkg::IDX_LAST;
    assign done           = (state != ctrlPkg::IDLE) && (xpt == lastStep);
    assign step           = xpt;
    assign notEnablePlain = (state != ctrlPkg::PLAIN);
    assign notEnableIdx   = (state != ctrlPkg::INDEXED);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ctrlPkg::IDLE;
            xpt   <= '0;
        end else if (state == ctrlPkg::IDLE) begin
            // A start while busy never reaches this branch.
            if (start) begin
                state <= startIdx ? ctrlPkg::INDEXED : ctrlPkg::PLAIN;
            end
            xpt <= '0;
        end else if (done) begin
            state <= ctrlPkg::IDLE;
            xpt   <= '0;
        end else begin
            xpt <= xpt + 2'd1;
        end
    end

endmodule

// File: cbOpDecoder.sv
// Step decoder for plain CB instructions on a register or on memory at HL.
module cbOpDecoder (
    input  logic          notEnable,
    input  ctrlPkg::stepT step,
    input  cbPkg::byteT   opcode,
    output logic          enableBit,
    output logic          readDt,
    output logic          selAddrHl,
    output logic          writeReg,
    output logic          writeMemHl
);

    logic isMem;
    logic noWrite;

    assign isMem = (opcode[2:0] == cbPkg::REG_MEM);

    // BIT only tests, and the SLL row does nothing at all.
    assign noWrite = (opcode[7:6] == 2'b01) || (opcode[7:3] == 5'b00110);

    always_comb begin
        enableBit  = 1'b0;
        readDt     = 1'b0;
        selAddrHl  = 1'b0;
        writeReg   = 1'b0;
        writeMemHl = 1'b0;
        if (!notEnable) begin
            if (!isMem) begin
                if (step == 2'd0) begin
                    readDt = 1'b1;
                end else if (step == ctrlPkg::PLAIN_LAST) begin
                    enableBit = 1'b1;
                    writeReg  = !noWrite;
                end
            end else begin
                // HL stays on the bus for the whole instruction.
                selAddrHl = 1'b1;
                if (step == 2'd1) begin
                    readDt = 1'b1;
                end else if (step == ctrlPkg::IDX_LAST) begin
                    enableBit  = 1'b1;
                    writeMemHl = !noWrite;
                end
            end
        end
    end

endmodule

// File: idxCbDecoder.sv
// Step decoder for DD CB and FD CB instructions on memory at IX or IY plus d.
module idxCbDecoder (
    input  logic          notEnable,
    input  logic          isY,
    input  ctrlPkg::stepT step,
    input  cbPkg::byteT   opcode,
    output logic          enableBit,
    output logic          addAlu,
    output logic          selIy,
    output logic          readDt,
    output logic          selAddrIdx,
    output logic          writeMemIdx
);

    logic noWrite;

    assign noWrite = (opcode[7:6] == 2'b01) || (opcode[7:3] == 5'b00110);
    assign selIy   = !notEnable && isY;

    always_comb begin
        enableBit   = 1'b0;
        addAlu      = 1'b0;
        readDt      = 1'b0;
        selAddrIdx  = 1'b0;
        writeMemIdx = 1'b0;
        if (!notEnable) begin
            case (step)
                2'd0: begin
                    addAlu = 1'b1;
                end
                2'd1: begin
                    selAddrIdx = 1'b1;
                    readDt     = 1'b1;
                end
                ctrlPkg::IDX_LAST: begin
                    selAddrIdx  = 1'b1;
                    enableBit   = 1'b1;
                    writeMemIdx = !noWrite;
                end
                default: begin
                    enableBit = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: bitOpDecoder.sv
// Maps the CB opcode byte to an ALU operation, bit index and flag write mask.
module bitOpDecoder (
    input  logic         enable,
    input  cbPkg::byteT  opcode,
    output cbPkg::aluOpT aluOp,
    output logic [2:0]   bitIdx,
    output cbPkg::flagsT flagMask
);

    // The y field doubles as the bit number for BIT, RES and SET.
    assign bitIdx = opcode[5:3];

    always_comb begin
        aluOp    = cbPkg::NOP;
        flagMask = '0;
        if (enable) begin
            case (opcode[7:6])
                2'b00: begin
                    case (opcode[5:3])
                        3'd0: aluOp = cbPkg::RLC;
                        3'd1: aluOp = cbPkg::RRC;
                        3'd2: aluOp = cbPkg::RL;
                        3'd3: aluOp = cbPkg::RR;
                        3'd4: aluOp = cbPkg::SLA;
                        3'd5: aluOp = cbPkg::SRA;
                        3'd7: aluOp = cbPkg::SRL;
                        default: aluOp = cbPkg::NOP;
                    endcase
                    if (opcode[5:3] != 3'd6) begin
                        flagMask = cbPkg::FLAGS_SHIFT;
                    end
                end
                2'b01: begin
                    aluOp    = cbPkg::BIT;
                    flagMask = cbPkg::FLAGS_BIT;
                end
                2'b10: aluOp = cbPkg::RES;
                default: aluOp = cbPkg::SET;
            endcase
        end
    end

endmodule

// File: cbDecodeMerge.sv
// Combines the plain and indexed step decoders and drives the shared bit-op decoder.
module cbDecodeMerge (
    input  logic          notEnablePlain,
    input  logic          notEnableIdx,
    input  logic          isY,
    input  ctrlPkg::stepT step,
    input  cbPkg::byteT   opcode,
    output logic          readDt,
    output logic          selAddrHl,
    output logic          selAddrIdx,
    output logic          addAlu,
    output logic          selIy,
    output logic          writeReg,
    output logic          writeMem,
    output cbPkg::aluOpT  aluOp,
    output logic [2:0]    bitIdx,
    output cbPkg::flagsT  flagMask
);

    logic enableBitPlain;
    logic enableBitIdx;
    logic readDtPlain;
    logic readDtIdx;
    logic writeMemHl;
    logic writeMemIdx;

    cbOpDecoder u_plain (
        .notEnable  (notEnablePlain),
        .step       (step),
        .opcode     (opcode),
        .enableBit  (enableBitPlain),
        .readDt     (readDtPlain),
        .selAddrHl  (selAddrHl),
        .writeReg   (writeReg),
        .writeMemHl (writeMemHl)
    );

    idxCbDecoder u_idx (
        .notEnable   (notEnableIdx),
        .isY         (isY),
        .step        (step),
        .opcode      (opcode),
        .enableBit   (enableBitIdx),
        .addAlu      (addAlu),
        .selIy       (selIy),
        .readDt      (readDtIdx),
        .selAddrIdx  (selAddrIdx),
        .writeMemIdx (writeMemIdx)
    );

    // ############################
    // Shared strobes
    // ############################

    assign readDt   = readDtPlain | readDtIdx;
    assign writeMem = writeMemHl | writeMemIdx;

    bitOpDecoder u_bitOp (
        .enable   (enableBitPlain | enableBitIdx),
        .opcode   (opcode),
        .aluOp    (aluOp),
        .bitIdx   (bitIdx),
        .flagMask (flagMask)
    );

endmodule

// File: bitAlu.sv
// Rotate, shift, BIT, RES and SET on the data latch with Z80 flag results.
module bitAlu (
    input  cbPkg::byteT  dt,
    input  cbPkg::aluOpT aluOp,
    input  logic [2:0]   bitIdx,
    input  cbPkg::flagsT flagsIn,
    output cbPkg::byteT  result,
    output cbPkg::flagsT flagsOut
);

    logic carry;
    logic tested;

    assign tested = dt[bitIdx];

    always_comb begin
        result   = dt;
        flagsOut = flagsIn;
        carry    = 1'b0;
        case (aluOp)
            cbPkg::RLC: {carry, result} = {dt[7], dt[6:0], dt[7]};
            cbPkg::RRC: {result, carry} = {dt[0], dt[7:1], dt[0]};
            cbPkg::RL:  {carry, result} = {dt, flagsIn[cbPkg::FLAG_C]};
            cbPkg::RR:  {result, carry} = {flagsIn[cbPkg::FLAG_C], dt};
            cbPkg::SLA: {carry, result} = {dt, 1'b0};
            cbPkg::SRA: {result, carry} = {dt[7], dt};
            cbPkg::SRL: {result, carry} = {1'b0, dt};
            cbPkg::RES: result[bitIdx] = 1'b0;
            cbPkg::SET: result[bitIdx] = 1'b1;
            default:    result = dt;
        endcase

        if (aluOp inside {cbPkg::RLC, cbPkg::RRC, cbPkg::RL, cbPkg::RR,
                          cbPkg::SLA, cbPkg::SRA, cbPkg::SRL}) begin
            flagsOut[cbPkg::FLAG_S]  = result[7];
            flagsOut[cbPkg::FLAG_Z]  = (result == '0);
            flagsOut[cbPkg::FLAG_H]  = 1'b0;
            flagsOut[cbPkg::FLAG_PV] = ~^result;
            flagsOut[cbPkg::FLAG_N]  = 1'b0;
            flagsOut[cbPkg::FLAG_C]  = carry;
        end else if (aluOp == cbPkg::BIT) begin
            // S only reflects the tested bit when that bit is the sign bit.
            flagsOut[cbPkg::FLAG_S]  = tested && (bitIdx == 3'd7);
            flagsOut[cbPkg::FLAG_Z]  = ~tested;
            flagsOut[cbPkg::FLAG_H]  = 1'b1;
            flagsOut[cbPkg::FLAG_PV] = ~tested;
            flagsOut[cbPkg::FLAG_N]  = 1'b0;
        end
    end

endmodule

// File: cbRegFile.sv
// Register file with B to A, IX, IY, data latch, address latch and flags.
module cbRegFile (
    input  logic          clk,
    input  logic          rstN,
    input  logic          loadEn,
    input  cbPkg::regSelT loadSel,
    input  cbPkg::byteT   loadData,
    input  logic          ixLoad,
    input  logic          iyLoad,
    input  cbPkg::addrT   idxData,
    input  logic          readDt,
    input  cbPkg::regSelT regSel,
    input  cbPkg::byteT   memRdata,
    input  logic          addAlu,
    input  logic          selIy,
    input  cbPkg::byteT   disp,
    input  logic          selAddrHl,
    input  logic          writeReg,
    input  cbPkg::byteT   result,
    input  cbPkg::flagsT  flagMask,
    input  cbPkg::flagsT  flagsNew,
    output cbPkg::byteT   dt,
    output cbPkg::addrT   memAddr,
    output cbPkg::flagsT  flags
);

    // Entry REG_MEM has no register behind it and stays zero.
    cbPkg::byteT regs [8];
    cbPkg::addrT ix;
    cbPkg::addrT iy;
    cbPkg::addrT addrLatch;

    assign memAddr = selAddrHl ? {regs[cbPkg::REG_H], regs[cbPkg::REG_L]} : addrLatch;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            ix        <= '0;
            iy        <= '0;
            dt        <= '0;
            addrLatch <= '0;
            flags     <= '0;
        end else begin
            if (loadEn && loadSel != cbPkg::REG_MEM) begin
                regs[loadSel] <= loadData;
            end
            if (ixLoad) begin
                ix <= idxData;
            end
            if (iyLoad) begin
                iy <= idxData;
            end
            if (readDt) begin
                dt <= (regSel == cbPkg::REG_MEM) ? memRdata : regs[regSel];
            end
            if (addAlu) begin
                addrLatch <= (selIy ? iy : ix) + {{8{disp[7]}}, disp};
            end
            if (writeReg) begin
                regs[regSel] <= result;
            end
            flags <= (flags & ~flagMask) | (flagsNew & flagMask);
        end
    end

endmodule

// File: cbExecUnit.sv
// CB execution unit top level that wires the sequencer, decoders, ALU and register file.
module cbExecUnit (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  logic          startIdx,
    input  logic          isY,
    input  cbPkg::byteT   opcode,
    input  cbPkg::byteT   disp,
    input  logic          loadEn,
    input  cbPkg::regSelT loadSel,
    input  cbPkg::byteT   loadData,
    input  logic          ixLoad,
    input  logic          iyLoad,
    input  cbPkg::addrT   idxData,
    output cbPkg::addrT   memAddr,
    input  cbPkg::byteT   memRdata,
    output logic          memWe,
    output cbPkg::byteT   memWdata,
    output logic          regWe,
    output cbPkg::regSelT regSel,
    output cbPkg::byteT   regData,
    output cbPkg::flagsT  flags,
    output logic          done
);

    ctrlPkg::stepT step;
    logic          notEnablePlain;
    logic          notEnableIdx;
    logic          idle;
    logic          readDt;
    logic          selAddrHl;
    logic          selAddrIdx;
    logic          addAlu;
    logic          selIy;
    cbPkg::aluOpT  aluOp;
    logic [2:0]    bitIdx;
    cbPkg::flagsT  flagMask;
    cbPkg::flagsT  flagsNew;
    cbPkg::byteT   dt;
    cbPkg::byteT   result;

    assign idle = notEnablePlain & notEnableIdx;

    // Indexed operands always come from memory, whatever the r field says.
    assign regSel   = selAddrIdx ? cbPkg::REG_MEM : opcode[2:0];
    assign regData  = result;
    assign memWdata = result;

    cbStepSequencer u_seq (
        .clk            (clk),
        .rstN           (rstN),
        .start          (start),
        .startIdx       (startIdx),
        .isRegOp        (opcode[2:0] != cbPkg::REG_MEM),
        .step           (step),
        .notEnablePlain (notEnablePlain),
        .notEnableIdx   (notEnableIdx),
        .done           (done)
    );

    cbDecodeMerge u_dec (
        .notEnablePlain (notEnablePlain),
        .notEnableIdx   (notEnableIdx),
        .isY            (isY),
        .step           (step),
        .opcode         (opcode),
        .readDt         (readDt),
        .selAddrHl      (selAddrHl),
        .selAddrIdx     (selAddrIdx),
        .addAlu         (addAlu),
        .selIy          (selIy),
        .writeReg       (regWe),
        .writeMem       (memWe),
        .aluOp          (aluOp),
        .bitIdx         (bitIdx),
        .flagMask       (flagMask)
    );

    bitAlu u_alu (
        .dt       (dt),
        .aluOp    (aluOp),
        .bitIdx   (bitIdx),
        .flagsIn  (flags),
        .result   (result),
        .flagsOut (flagsNew)
    );

    cbRegFile u_regs (
        .clk       (clk),
        .rstN      (rstN),
        .loadEn    (loadEn & idle),
        .loadSel   (loadSel),
        .loadData  (loadData),
        .ixLoad    (ixLoad & idle),
        .iyLoad    (iyLoad & idle),
        .idxData   (idxData),
        .readDt    (readDt),
        .regSel    (regSel),
        .memRdata  (memRdata),
        .addAlu    (addAlu),
        .selIy     (selIy),
        .disp      (disp),
        .selAddrHl (selAddrHl),
        .writeReg  (regWe),
        .result    (result),
        .flagMask  (flagMask),
        .flagsNew  (flagsNew),
        .dt        (dt),
        .memAddr   (memAddr),
        .flags     (flags)
    );

endmodule

// File: tb_cbExecUnit.sv
// Testbench for the CB execution unit with random plain and indexed CB instructions.
module tb_cbExecUnit;

    localparam int NUM_INSTR      = 300;
    localparam int RESET_CYCLES   = 4;
    localparam int PRELOAD_CYCLES = 11;
    // No instruction needs more than 4 cycles from its start to the next start.
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + PRELOAD_CYCLES + RESET_CYCLES + 2;

    logic          clk;
    logic          rstN;
    logic          start;
    logic          startIdx;
    logic          isY;
    cbPkg::byteT   opcode;
    cbPkg::byteT   disp;
    logic          loadEn;
    cbPkg::regSelT loadSel;
    cbPkg::byteT   loadData;
    logic          ixLoad;
    logic          iyLoad;
    cbPkg::addrT   idxData;
    cbPkg::addrT   memAddr;
    cbPkg::byteT   memRdata;
    logic          memWe;
    cbPkg::byteT   memWdata;
    logic          regWe;
    cbPkg::regSelT regSel;
    cbPkg::byteT   regData;
    cbPkg::flagsT  flags;
    logic          done;

    cbPkg::byteT   tbMem [256];
    cbPkg::byteT   refRegs [8];
    cbPkg::addrT   refIx;
    cbPkg::addrT   refIy;
    cbPkg::flagsT  expFlags;
    logic          inFlight;
    logic [31:0]   lfsr = 32'h9f50695c;
    int            cycleCount = 0;

    cbExecUnit u_dut (.*);

    always #4 clk = ~clk;

    // ##############################
    // Memory model and monitors
    // ##############################

    // The high address byte is ignored, so the memory aliases every 256 bytes.
    assign memRdata = tbMem[memAddr[7:0]];

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                tbMem[8'(i)] <= 8'(i * 29) ^ 8'h5c;
            end
        end else if (memWe) begin
            tbMem[memAddr[7:0]] <= memWdata;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            failRun("timeout, the run did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (rstN) begin
            assert (done || (!regWe && !memWe))
            else failRun("a write strobe was active outside the done cycle");
            assert (!done || inFlight)
            else failRun("done was asserted while no instruction was running");
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp)
        else failRun($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for each bit taken.
    function automatic cbPkg::byteT randByte(input int n);
        cbPkg::byteT val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[6:0], fb};
        end
        return val;
    endfunction

    // Expected result, flags and write enable of one CB opcode on an operand.
    function automatic void computeExpected(input cbPkg::byteT op, input cbPkg::byteT val,
                                            input cbPkg::flagsT fIn, output cbPkg::byteT res,
                                            output cbPkg::flagsT fOut, output logic wr);
        logic [2:0] y;
        logic       c;
        logic       tested;
        y      = op[5:3];
        res    = val;
        fOut   = fIn;
        c      = 1'b0;
        tested = val[y];
        wr     = (op[7:6] != 2'b01) && !(op[7:6] == 2'b00 && y == 3'd6);
        case (op[7:6])
            2'b00: begin
                case (y)
                    3'd0: {c, res} = {val, val[7]};
                    3'd1: {res, c} = {val[0], val};
                    3'd2: {c, res} = {val, fIn[cbPkg::FLAG_C]};
                    3'd3: {res, c} = {fIn[cbPkg::FLAG_C], val};
                    3'd4: {c, res} = {val, 1'b0};
                    3'd5: {res, c} = {val[7], val};
                    3'd7: {res, c} = {1'b0, val};
                    default: res = val;
                endcase
                if (wr) begin
                    fOut[cbPkg::FLAG_S]  = res[7];
                    fOut[cbPkg::FLAG_Z]  = (res == 8'h00);
                    fOut[cbPkg::FLAG_H]  = 1'b0;
                    fOut[cbPkg::FLAG_PV] = ~^res;
                    fOut[cbPkg::FLAG_N]  = 1'b0;
                    fOut[cbPkg::FLAG_C]  = c;
                end
            end
            2'b01: begin
                fOut[cbPkg::FLAG_S]  = tested && (y == 3'd7);
                fOut[cbPkg::FLAG_Z]  = !tested;
                fOut[cbPkg::FLAG_H]  = 1'b1;
                fOut[cbPkg::FLAG_PV] = !tested;
                fOut[cbPkg::FLAG_N]  = 1'b0;
            end
            2'b10: res[y] = 1'b0;
            default: res[y] = 1'b1;
        endcase
    endfunction

    // Starts one random instruction, optionally with a register load and a second start
    // while busy, and checks its latency and its write at done.
    task automatic runInstr();
        cbPkg::byteT   op;
        cbPkg::byteT   d;
        logic          idx;
        logic          useY;
        logic          busyStart;
        logic          doLoad;
        cbPkg::regSelT lSel;
        cbPkg::byteT   lData;
        cbPkg::regSelT r;
        logic          onMem;
        cbPkg::addrT   addr;
        cbPkg::byteT   operand;
        cbPkg::byteT   res;
        cbPkg::flagsT  fNew;
        logic          wr;
        int            latency;
        int            waited;
        op        = randByte(8);
        d         = randByte(8);
        idx       = 1'(randByte(1));
        useY      = 1'(randByte(1));
        busyStart = 1'(randByte(1));
        doLoad    = 1'(randByte(1));
        lSel      = 3'(randByte(3));
        lData     = randByte(8);
        r         = op[2:0];
        if (doLoad && lSel != cbPkg::REG_MEM) begin
            refRegs[lSel] = lData;
        end
        start    = 1'b1;
        startIdx = idx;
        isY      = useY;
        opcode   = op;
        disp     = d;
        loadEn   = doLoad;
        loadSel  = lSel;
        loadData = lData;
        inFlight = 1'b1;

        onMem   = idx || (r == cbPkg::REG_MEM);
        addr    = idx ? (useY ? refIy : refIx) + {{8{d[7]}}, d}
                      : {refRegs[cbPkg::REG_H], refRegs[cbPkg::REG_L]};
        latency = onMem ? 3 : 2;
        operand = onMem ? tbMem[addr[7:0]] : refRegs[r];
        computeExpected(op, operand, expFlags, res, fNew, wr);

        // Flags of the previous instruction are still in place here.
        @(negedge clk);
        checkValue("flags", 16'(flags), 16'(expFlags));
        checkValue("done", 16'(done), 16'h0000);
        expFlags = fNew;

        waited = 0;
        do begin
            @(posedge clk);
            #1;
            start  = busyStart && (waited == 0);
            loadEn = 1'b0;
            @(negedge clk);
            waited++;
        end while (!done);

        checkValue("done latency", 16'(waited), 16'(latency));
        if (onMem) begin
            checkValue("regWe", 16'(regWe), 16'h0000);
            checkValue("memWe", 16'(memWe), 16'(wr));
            checkValue("memAddr", memAddr, addr);
            if (wr) begin
                checkValue("memWdata", 16'(memWdata), 16'(res));
            end
        end else begin
            checkValue("memWe", 16'(memWe), 16'h0000);
            checkValue("regWe", 16'(regWe), 16'(wr));
            if (wr) begin
                checkValue("regSel", 16'(regSel), 16'(r));
                checkValue("regData", 16'(regData), 16'(res));
                refRegs[r] = res;
            end
        end
        @(posedge clk);
        #1;
        inFlight = 1'b0;
    endtask

    initial begin
        cbPkg::byteT hi;
        cbPkg::byteT lo;
        clk      = 1'b0;
        rstN     = 1'b0;
        start    = 1'b0;
        startIdx = 1'b0;
        isY      = 1'b0;
        opcode   = '0;
        disp     = '0;
        loadEn   = 1'b0;
        loadSel  = '0;
        loadData = '0;
        ixLoad   = 1'b0;
        iyLoad   = 1'b0;
        idxData  = '0;
        inFlight = 1'b0;
        expFlags = '0;
        refIx    = '0;
        refIy    = '0;
        for (int i = 0; i < 8; i++) begin
            refRegs[3'(i)] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkValue("done", 16'(done), 16'h0000);
        checkValue("regWe", 16'(regWe), 16'h0000);
        checkValue("memWe", 16'(memWe), 16'h0000);

        // Preload B to A, then IX and IY.
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            loadEn   = 1'b1;
            loadSel  = 3'(i);
            loadData = randByte(8);
            if (loadSel != cbPkg::REG_MEM) begin
                refRegs[loadSel] = loadData;
            end
        end
        @(posedge clk);
        #1;
        hi      = randByte(8);
        lo      = randByte(8);
        loadEn  = 1'b0;
        ixLoad  = 1'b1;
        idxData = {hi, lo};
        refIx   = {hi, lo};
        @(posedge clk);
        #1;
        hi      = randByte(8);
        lo      = randByte(8);
        ixLoad  = 1'b0;
        iyLoad  = 1'b1;
        idxData = {hi, lo};
        refIy   = {hi, lo};
        @(posedge clk);
        #1;
        iyLoad = 1'b0;

        repeat (NUM_INSTR) runInstr();

        @(negedge clk);
        checkValue("flags", 16'(flags), 16'(expFlags));
        $display("Verification passed");
        $finish;
    end

endmodule

// File: sources.f
cbPkg.sv
ctrlPkg.sv
cbStepSequencer.sv
cbOpDecoder.sv
idxCbDecoder.sv
bitOpDecoder.sv
cbDecodeMerge.sv
bitAlu.sv
cbRegFile.sv
cbExecUnit.sv
tb_cbExecUnit.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the CB execution unit testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_cbExecUnit \
    --Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
